/* source/xbar_pkg.sv */
//********************************************************************
// Shared sizes, fixed address map and request/response structs
// for the two-initiator, two-target lite crossbar
//********************************************************************

package xbar_pkg;

  localparam int unsigned NUM_INIT  = 2;
  localparam int unsigned NUM_TGT   = 2;
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned TGT_IDX_W = 1;

  // Address map, entry 0 sits in the low bits
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_BASE = {
    32'h0000_1000,  // Target 1
    32'h0000_0000   // Target 0
  };
  localparam logic [ADDR_W-1:0] TGT_SIZE = 32'h0000_1000;  // Same window size for all targets

  // Read data returned with a decode error
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEAD_BEEF;

  // Single-beat request
  typedef struct packed {
    logic              write;  // 1 = write, 0 = read
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } xbar_req_t;

  // Response; writes carry zero read data
  typedef struct packed {
    logic              error;
    logic [DATA_W-1:0] rdata;
  } xbar_resp_t;

  typedef logic [$clog2(NUM_INIT)-1:0] init_idx_t;

endpackage

/* source/spill_reg.sv */
//********************************************************************
// One-entry valid/ready register slice, generic payload
//********************************************************************

`timescale 1ns/1ps

module spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;

  // Empty, or drained in this very cycle
  assign ready_o = ~full_q | ready_i;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;  // Load on every accepted beat
    end
  end

  a_hold_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_o && !ready_i) |=> $stable(data_o))
    else $error("spill_reg output changed while stalled");

endmodule

/* source/addr_decoder.sv */
//********************************************************************
// Address map lookup against the fixed target windows
//********************************************************************

`timescale 1ns/1ps

module addr_decoder
  import xbar_pkg::*;
(
  input  logic [ADDR_W-1:0]    addr_i,
  output logic [TGT_IDX_W-1:0] idx_o,
  output logic                 dec_error_o
);

  logic [NUM_TGT-1:0] hit;

  // One compare pair per window
  always_comb begin
    for (int unsigned t = 0; t < NUM_TGT; t++) begin
      hit[t] = (addr_i >= TGT_BASE[t]) && (addr_i < (TGT_BASE[t] + TGT_SIZE));
    end
  end

  // Windows do not overlap, so the last hit is the only hit
  always_comb begin
    idx_o       = '0;
    dec_error_o = 1'b1;
    for (int unsigned t = 0; t < NUM_TGT; t++) begin
      if (hit[t]) begin
        idx_o       = TGT_IDX_W'(t);
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

/* source/initiator_demux.sv */
//********************************************************************
// Per-initiator request routing with a single transaction in flight
// and a local error responder for unmapped addresses
//********************************************************************

`timescale 1ns/1ps

module initiator_demux
  import xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Initiator side
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  xbar_req_t                 req_i,
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output xbar_resp_t                resp_o,
  // Toward the target muxes
  output logic       [NUM_TGT-1:0]  tgt_req_valid_o,
  input  logic       [NUM_TGT-1:0]  tgt_req_ready_i,
  output xbar_req_t                 tgt_req_o,
  input  logic       [NUM_TGT-1:0]  tgt_resp_valid_i,
  output logic       [NUM_TGT-1:0]  tgt_resp_ready_o,
  input  xbar_resp_t [NUM_TGT-1:0]  tgt_resp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,  // Ready for a new request
    ST_BUSY,  // Waiting on the stored target
    ST_ERR    // Answering a decode error locally
  } state_e;

  state_e               state_q;
  logic [TGT_IDX_W-1:0] tgt_q;
  logic [TGT_IDX_W-1:0] dec_idx;
  logic                 dec_error;
  logic                 req_xfer;
  logic                 resp_xfer;

  addr_decoder u_decoder (
    .addr_i      ( req_i.addr ),
    .idx_o       ( dec_idx    ),
    .dec_error_o ( dec_error  )
  );

  assign tgt_req_o = req_i;  // Payload goes to every mux, valid selects one

  always_comb begin
    tgt_req_valid_o  = '0;
    tgt_resp_ready_o = '0;
    req_ready_o      = 1'b0;
    resp_valid_o     = 1'b0;
    resp_o           = '0;
    case (state_q)
      ST_IDLE: begin
        if (dec_error) begin
          req_ready_o = 1'b1;  // Swallowed here, no target sees it
        end else begin
          tgt_req_valid_o[dec_idx] = req_valid_i;
          req_ready_o              = tgt_req_ready_i[dec_idx];
        end
      end
      ST_BUSY: begin
        resp_valid_o            = tgt_resp_valid_i[tgt_q];
        resp_o                  = tgt_resp_i[tgt_q];
        tgt_resp_ready_o[tgt_q] = resp_ready_i;
      end
      ST_ERR: begin
        resp_valid_o = 1'b1;
        resp_o.error = 1'b1;
        resp_o.rdata = ERR_RDATA;
      end
      default: begin
        resp_valid_o = 1'b0;
      end
    endcase
  end

  assign req_xfer  = req_valid_i & req_ready_o;
  assign resp_xfer = resp_valid_o & resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      tgt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_xfer) begin
            state_q <= dec_error ? ST_ERR : ST_BUSY;
            tgt_q   <= dec_idx;
          end
        end
        ST_BUSY, ST_ERR: begin
          if (resp_xfer) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // The payload is routed combinationally, so the decode must not move under a stall
  a_req_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i)))
    else $error("initiator request changed while waiting");

endmodule

/* source/target_mux.sv */
//********************************************************************
// Per-target round-robin arbiter with grant lock until the
// response has been handed back to the winning initiator
//********************************************************************

`timescale 1ns/1ps

module target_mux
  import xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // From the initiator demuxes
  input  logic       [NUM_INIT-1:0] init_req_valid_i,
  output logic       [NUM_INIT-1:0] init_req_ready_o,
  input  xbar_req_t  [NUM_INIT-1:0] init_req_i,
  // Toward the target request stage
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output xbar_req_t                 req_o,
  // Target response
  input  logic                      resp_valid_i,
  output logic                      resp_ready_o,
  input  xbar_resp_t                resp_i,
  // Back to the initiator demuxes
  output logic       [NUM_INIT-1:0] init_resp_valid_o,
  input  logic       [NUM_INIT-1:0] init_resp_ready_i,
  output xbar_resp_t                init_resp_o
);

  init_idx_t rr_q;        // Highest priority on the next arbitration
  init_idx_t lock_idx_q;
  logic      lock_q;
  init_idx_t gnt_idx;
  logic      gnt_valid;
  logic      req_xfer;
  logic      resp_xfer;

  // First valid initiator at or after the pointer
  always_comb begin : arbiter
    init_idx_t cand;
    gnt_valid = 1'b0;
    gnt_idx   = rr_q;
    for (int unsigned k = 0; k < NUM_INIT; k++) begin
      cand = init_idx_t'((32'(rr_q) + k) % NUM_INIT);
      if (!gnt_valid && init_req_valid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  always_comb begin
    req_valid_o       = 1'b0;
    req_o             = init_req_i[gnt_idx];
    init_req_ready_o  = '0;
    init_resp_valid_o = '0;
    resp_ready_o      = 1'b0;
    if (lock_q) begin
      init_resp_valid_o[lock_idx_q] = resp_valid_i;  // Only the owner sees it
      resp_ready_o                  = init_resp_ready_i[lock_idx_q];
    end else begin
      req_valid_o               = gnt_valid;
      init_req_ready_o[gnt_idx] = req_ready_i & gnt_valid;
    end
  end

  assign init_resp_o = resp_i;  // Valid alone tells the demuxes who owns it

  assign req_xfer  = req_valid_o & req_ready_i;
  assign resp_xfer = resp_valid_i & resp_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      rr_q       <= '0;
    end else if (req_xfer) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
      rr_q       <= init_idx_t'((32'(gnt_idx) + 1) % NUM_INIT);
    end else if (resp_xfer) begin
      lock_q <= 1'b0;
    end
  end

  // A target can only answer a request that was granted and not yet answered
  a_resp_locked : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i |-> lock_q)
    else $error("target response while mux not locked");

endmodule

/* source/lite_xbar.sv */
//********************************************************************
// Top level: initiator demuxes, target muxes, spill stages and
// the cross wiring between them
//********************************************************************

`timescale 1ns/1ps

module lite_xbar
  import xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Initiator ports
  input  logic       [NUM_INIT-1:0] init_req_valid_i,
  output logic       [NUM_INIT-1:0] init_req_ready_o,
  input  xbar_req_t  [NUM_INIT-1:0] init_req_i,
  output logic       [NUM_INIT-1:0] init_resp_valid_o,
  input  logic       [NUM_INIT-1:0] init_resp_ready_i,
  output xbar_resp_t [NUM_INIT-1:0] init_resp_o,
  // Target ports
  output logic       [NUM_TGT-1:0]  tgt_req_valid_o,
  input  logic       [NUM_TGT-1:0]  tgt_req_ready_i,
  output xbar_req_t  [NUM_TGT-1:0]  tgt_req_o,
  input  logic       [NUM_TGT-1:0]  tgt_resp_valid_i,
  output logic       [NUM_TGT-1:0]  tgt_resp_ready_o,
  input  xbar_resp_t [NUM_TGT-1:0]  tgt_resp_i
);

  // Demux side, [initiator][target]
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_req_ready;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_resp_valid;
  logic [NUM_INIT-1:0][NUM_TGT-1:0] dmx_resp_ready;
  xbar_req_t [NUM_INIT-1:0]         dmx_req;

  // Mux side, [target][initiator]
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_req_ready;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_resp_valid;
  logic [NUM_TGT-1:0][NUM_INIT-1:0] mux_resp_ready;
  xbar_resp_t [NUM_TGT-1:0]         mux_resp;

  logic [NUM_TGT-1:0]               mux_out_valid;  // Mux into request spill
  logic [NUM_TGT-1:0]               mux_out_ready;
  xbar_req_t [NUM_TGT-1:0]          mux_out;
  logic [NUM_INIT-1:0]              rsp_valid;      // Demux into response spill
  logic [NUM_INIT-1:0]              rsp_ready;
  xbar_resp_t [NUM_INIT-1:0]        rsp;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross_init
    for (genvar t = 0; t < NUM_TGT; t++) begin : gen_cross_tgt
      assign mux_req_valid[t][i]  = dmx_req_valid[i][t];
      assign dmx_req_ready[i][t]  = mux_req_ready[t][i];
      assign dmx_resp_valid[i][t] = mux_resp_valid[t][i];
      assign mux_resp_ready[t][i] = dmx_resp_ready[i][t];
    end
  end

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    initiator_demux u_demux (
      .clk_i            ( clk_i                ),
      .arst_n_i         ( arst_n_i             ),
      .req_valid_i      ( init_req_valid_i[i]  ),
      .req_ready_o      ( init_req_ready_o[i]  ),
      .req_i            ( init_req_i[i]        ),
      .resp_valid_o     ( rsp_valid[i]         ),
      .resp_ready_i     ( rsp_ready[i]         ),
      .resp_o           ( rsp[i]               ),
      .tgt_req_valid_o  ( dmx_req_valid[i]     ),
      .tgt_req_ready_i  ( dmx_req_ready[i]     ),
      .tgt_req_o        ( dmx_req[i]           ),
      .tgt_resp_valid_i ( dmx_resp_valid[i]    ),
      .tgt_resp_ready_o ( dmx_resp_ready[i]    ),
      .tgt_resp_i       ( mux_resp             )
    );

    spill_reg #(
      .payload_t ( xbar_resp_t )
    ) u_resp_spill (
      .clk_i    ( clk_i                ),
      .arst_n_i ( arst_n_i             ),
      .valid_i  ( rsp_valid[i]         ),
      .ready_o  ( rsp_ready[i]         ),
      .data_i   ( rsp[i]               ),
      .valid_o  ( init_resp_valid_o[i] ),
      .ready_i  ( init_resp_ready_i[i] ),
      .data_o   ( init_resp_o[i]       )
    );
  end

  for (genvar t = 0; t < NUM_TGT; t++) begin : gen_tgt
    target_mux u_mux (
      .clk_i             ( clk_i               ),
      .arst_n_i          ( arst_n_i            ),
      .init_req_valid_i  ( mux_req_valid[t]    ),
      .init_req_ready_o  ( mux_req_ready[t]    ),
      .init_req_i        ( dmx_req             ),
      .req_valid_o       ( mux_out_valid[t]    ),
      .req_ready_i       ( mux_out_ready[t]    ),
      .req_o             ( mux_out[t]          ),
      .resp_valid_i      ( tgt_resp_valid_i[t] ),
      .resp_ready_o      ( tgt_resp_ready_o[t] ),
      .resp_i            ( tgt_resp_i[t]       ),
      .init_resp_valid_o ( mux_resp_valid[t]   ),
      .init_resp_ready_i ( mux_resp_ready[t]   ),
      .init_resp_o       ( mux_resp[t]         )
    );

    spill_reg #(
      .payload_t ( xbar_req_t )
    ) u_req_spill (
      .clk_i    ( clk_i              ),
      .arst_n_i ( arst_n_i           ),
      .valid_i  ( mux_out_valid[t]   ),
      .ready_o  ( mux_out_ready[t]   ),
      .data_i   ( mux_out[t]         ),
      .valid_o  ( tgt_req_valid_o[t] ),
      .ready_i  ( tgt_req_ready_i[t] ),
      .data_o   ( tgt_req_o[t]       )
    );
  end

endmodule

/* verif/tb_lite_xbar.sv */
//**********************************************************************
// Testbench for the lite crossbar with clock, reset, target memory
// models, replay of the case file, response and routing checks
//**********************************************************************

`timescale 1ns/1ps

module tb_lite_xbar
  import xbar_pkg::*;
();

  localparam int unsigned MEM_WORDS = 1024;  // One 4 KiB window per target

  logic                      clk_i;
  logic                      arst_n_i;
  logic       [NUM_INIT-1:0] init_req_valid_i;
  logic       [NUM_INIT-1:0] init_req_ready_o;
  xbar_req_t  [NUM_INIT-1:0] init_req_i;
  logic       [NUM_INIT-1:0] init_resp_valid_o;
  logic       [NUM_INIT-1:0] init_resp_ready_i;
  xbar_resp_t [NUM_INIT-1:0] init_resp_o;
  logic       [NUM_TGT-1:0]  tgt_req_valid_o;
  logic       [NUM_TGT-1:0]  tgt_req_ready_i;
  xbar_req_t  [NUM_TGT-1:0]  tgt_req_o;
  logic       [NUM_TGT-1:0]  tgt_resp_valid_i;
  logic       [NUM_TGT-1:0]  tgt_resp_ready_o;
  xbar_resp_t [NUM_TGT-1:0]  tgt_resp_i;

  // Case table with one entry per line of the file
  string      c_name[$];
  int         c_init[$];
  int         c_grp[$];
  xbar_req_t  c_req[$];
  xbar_resp_t c_exp[$];

  integer            seed;
  int                val_errors;
  int                proto_errors;
  int                cycles;
  int                limit;
  int                tgt_hits;
  int                issued[NUM_INIT];
  int                resp_seen[NUM_INIT];
  logic              req_open[NUM_INIT];  // Issued but not yet seen at a target
  xbar_req_t         cur_req[NUM_INIT];
  int                first_grant[NUM_TGT];
  int                last_grant[NUM_TGT];
  logic [DATA_W-1:0] mem[NUM_TGT][MEM_WORDS];

  lite_xbar UUT (
    .clk_i             ( clk_i             ),
    .arst_n_i          ( arst_n_i          ),
    .init_req_valid_i  ( init_req_valid_i  ),
    .init_req_ready_o  ( init_req_ready_o  ),
    .init_req_i        ( init_req_i        ),
    .init_resp_valid_o ( init_resp_valid_o ),
    .init_resp_ready_i ( init_resp_ready_i ),
    .init_resp_o       ( init_resp_o       ),
    .tgt_req_valid_o   ( tgt_req_valid_o   ),
    .tgt_req_ready_i   ( tgt_req_ready_i   ),
    .tgt_req_o         ( tgt_req_o         ),
    .tgt_resp_valid_i  ( tgt_resp_valid_i  ),
    .tgt_resp_ready_o  ( tgt_resp_ready_o  ),
    .tgt_resp_i        ( tgt_resp_i        )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Background content of unwritten memory words
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'h5A5A_5A5A;
  endfunction

  // Index of the window that holds the address or -1 when unmapped
  function automatic int target_of(input logic [ADDR_W-1:0] addr);
    int hit;
    hit = -1;
    for (int t = 0; t < NUM_TGT; t++) begin
      if (addr >= TGT_BASE[t] && addr < TGT_BASE[t] + TGT_SIZE) hit = t;
    end
    return hit;
  endfunction

  task automatic load_cases();
    int                fd;
    int                code;
    int                ini;
    int                wr;
    int                grp;
    int                err;
    string             name;
    string             rest;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    xbar_req_t         req;
    xbar_resp_t        exp;
    fd = $fopen("verif/xbar_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/xbar_cases.txt");
      proto_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) break;
        if (name[0] == "#") begin
          code = $fgets(rest, fd);  // Comment line
        end else begin
          code = $fscanf(fd, "%d %d %h %h %d %d %h", ini, wr, addr, wdata, grp, err, rdata);
          if (code != 7) begin
            $display("Case line %s is malformed", name);
            proto_errors++;
            break;
          end
          req.write = wr[0];
          req.addr  = addr;
          req.wdata = wdata;
          exp.error = err[0];
          exp.rdata = rdata;
          c_name.push_back(name);
          c_init.push_back(ini);
          c_grp.push_back(grp);
          c_req.push_back(req);
          c_exp.push_back(exp);
        end
      end
      $fclose(fd);
    end
  endtask

  // Match a received request to a pending initiator and check its window
  task automatic check_routing(input int t, input xbar_req_t req);
    int owner;
    owner = -1;
    assert (req.addr >= TGT_BASE[t] && req.addr < TGT_BASE[t] + TGT_SIZE) else begin
      $display("Target %0d received address %h outside its window", t, req.addr);
      proto_errors++;
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      if (owner < 0 && req_open[i] && req == cur_req[i]) owner = i;
    end
    assert (owner >= 0) else begin
      $display("Target %0d received a request that no initiator has pending", t);
      proto_errors++;
    end
    if (owner >= 0) begin
      req_open[owner] = 1'b0;
      if (first_grant[t] < 0) first_grant[t] = owner;
      last_grant[t] = owner;
    end
  endtask

  // Behavioral memory with random accept and answer delays
  task automatic serve_target(input int t);
    xbar_req_t req;
    int        delay;
    forever begin
      @(negedge clk_i);
      tgt_resp_valid_i[t] = 1'b0;
      tgt_req_ready_i[t]  = ($unsigned($random(seed)) % 4) != 0;
      @(posedge clk_i);
      if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
        req = tgt_req_o[t];
        tgt_hits++;
        check_routing(t, req);
        @(negedge clk_i);
        tgt_req_ready_i[t] = 1'b0;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        tgt_resp_i[t].error = 1'b0;
        if (req.write) begin
          mem[t][req.addr[11:2]] = req.wdata;
          tgt_resp_i[t].rdata    = '0;
        end else begin
          tgt_resp_i[t].rdata = mem[t][req.addr[11:2]];
        end
        tgt_resp_valid_i[t] = 1'b1;
        do @(posedge clk_i); while (!tgt_resp_ready_o[t]);
      end
    end
  endtask

  task automatic watch_responses();
    forever begin
      @(posedge clk_i);
      for (int i = 0; i < NUM_INIT; i++) begin
        if (init_resp_valid_o[i] && init_resp_ready_i[i]) resp_seen[i]++;
      end
    end
  endtask

  // One transaction with a request handshake and a stalled response collection
  task automatic issue_txn(input int i, input int k);
    xbar_resp_t got;
    xbar_resp_t held;
    logic       held_valid;
    logic       done;
    @(negedge clk_i);
    cur_req[i]          = c_req[k];
    req_open[i]         = 1'b1;
    init_req_i[i]       = c_req[k];
    init_req_valid_i[i] = 1'b1;
    do @(posedge clk_i); while (!init_req_ready_o[i]);
    issued[i]++;
    @(negedge clk_i);
    init_req_valid_i[i] = 1'b0;
    held_valid          = 1'b0;
    done                = 1'b0;
    got                 = '0;
    held                = '0;
    while (!done) begin
      init_resp_ready_i[i] = ($unsigned($random(seed)) % 3) != 0;
      @(posedge clk_i);
      if (held_valid) begin
        assert (init_resp_valid_o[i] && init_resp_o[i] == held) else begin
          $display("Response on initiator %0d changed while stalled in %s", i, c_name[k]);
          proto_errors++;
        end
      end
      held_valid = init_resp_valid_o[i] && !init_resp_ready_i[i];
      held       = init_resp_o[i];
      if (init_resp_valid_o[i] && init_resp_ready_i[i]) begin
        got  = init_resp_o[i];
        done = 1'b1;
      end
      @(negedge clk_i);
    end
    init_resp_ready_i[i] = 1'b0;
    req_open[i]          = 1'b0;
    assert (got == c_exp[k]) else begin
      $display("[ERROR] %s: expected error=%0b rdata=%h, actual error=%0b rdata=%h",
               c_name[k], c_exp[k].error, c_exp[k].rdata, got.error, got.rdata);
      val_errors++;
    end
  endtask

  task automatic run_initiator(input int i, input int first, input int last);
    for (int k = first; k < last; k++) begin
      if (c_init[k] == i) issue_txn(i, k);
    end
  endtask

  initial begin : main_seq
    int k;
    int g_end;
    int t0;
    int pair_tgt;
    int exp_first;
    int mapped;
    seed              = 41;
    arst_n_i          = 1'b0;
    init_req_valid_i  = '0;
    init_req_i        = '0;
    init_resp_ready_i = '0;
    tgt_req_ready_i   = '0;
    tgt_resp_valid_i  = '0;
    tgt_resp_i        = '0;
    val_errors        = 0;
    proto_errors      = 0;
    cycles            = 0;
    limit             = 0;
    tgt_hits          = 0;
    mapped            = 0;
    for (int i = 0; i < NUM_INIT; i++) begin
      issued[i]    = 0;
      resp_seen[i] = 0;
      req_open[i]  = 1'b0;
      cur_req[i]   = '0;
    end
    for (int t = 0; t < NUM_TGT; t++) begin
      first_grant[t] = -1;
      last_grant[t]  = NUM_INIT - 1;  // Pointer starts at initiator 0
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[t][w] = fill_word(TGT_BASE[t] + ADDR_W'(w * 4));
      end
    end
    load_cases();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    limit    = 40 * c_name.size();
    fork
      serve_target(0);
      serve_target(1);
      watch_responses();
    join_none
    k = 0;
    while (k < c_name.size()) begin
      g_end = k;
      while (g_end < c_name.size() && c_grp[g_end] == c_grp[k]) g_end++;
      // Two simultaneous requests to one target leave the order to the round robin
      pair_tgt = -1;
      exp_first = 0;
      if (g_end - k == 2 && c_init[k] != c_init[k + 1]) begin
        t0 = target_of(c_req[k].addr);
        if (t0 >= 0 && t0 == target_of(c_req[k + 1].addr)) begin
          pair_tgt  = t0;
          exp_first = (last_grant[t0] + 1) % NUM_INIT;
        end
      end
      for (int t = 0; t < NUM_TGT; t++) first_grant[t] = -1;
      fork
        run_initiator(0, k, g_end);
        run_initiator(1, k, g_end);
      join
      if (pair_tgt >= 0) begin
        assert (first_grant[pair_tgt] == exp_first) else begin
          $display("[ERROR] %s: expected first grant to initiator %0d, actual %0d",
                   c_name[k], exp_first, first_grant[pair_tgt]);
          val_errors++;
        end
      end
      k = g_end;
    end
    @(negedge clk_i);
    init_resp_ready_i = '1;  // Any stray or repeated response is taken and counted
    repeat (5) @(posedge clk_i);
    for (int n = 0; n < c_name.size(); n++) begin
      if (!c_exp[n].error) mapped++;
    end
    for (int i = 0; i < NUM_INIT; i++) begin
      assert (resp_seen[i] == issued[i]) else begin
        $display("Initiator %0d got %0d responses for %0d requests", i, resp_seen[i], issued[i]);
        proto_errors++;
      end
    end
    assert (tgt_hits == mapped) else begin
      $display("Targets saw %0d requests while %0d were mapped", tgt_hits, mapped);
      proto_errors++;
    end
    $display("Checks done: %0d value errors, %0d protocol errors", val_errors, proto_errors);
    if (val_errors + proto_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, a transaction never completed", cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verif/xbar_cases.txt */
# name initiator write addr(hex) wdata(hex) group exp_error exp_rdata(hex)
# Lines sharing a group number are issued on both initiators at once
wr_t0_a         0 1 00000010 11112222 0  0 00000000
rd_t0_a         0 0 00000010 00000000 1  0 11112222
wr_t1_a         1 1 00001020 33334444 2  0 00000000
rd_t1_a         1 0 00001020 00000000 3  0 33334444
rd_cross_t0     1 0 00000010 00000000 4  0 11112222
rd_cross_t1     0 0 00001020 00000000 4  0 33334444
rd_fill_t0      0 0 00000100 00000000 5  0 5A5A5B5A
rd_fill_t1      1 0 00001FFC 00000000 5  0 5A5A45A6
err_gap         0 0 00002000 00000000 6  1 DEADBEEF
err_high        1 1 FFFFFFF0 12345678 6  1 DEADBEEF
err_wr          0 1 80000000 CAFEF00D 7  1 DEADBEEF
pair_wr_t0_i0   0 1 00000040 AAAA0001 8  0 00000000
pair_wr_t0_i1   1 1 00000044 BBBB0001 8  0 00000000
pair_rd_t0_i0   0 0 00000044 00000000 9  0 BBBB0001
pair_rd_t0_i1   1 0 00000040 00000000 9  0 AAAA0001
solo_wr_t0_i1   1 1 00000048 0000CC01 10 0 00000000
pair2_rd_t0_i0  0 0 00000048 00000000 11 0 0000CC01
pair2_rd_t0_i1  1 0 00000010 00000000 11 0 11112222
pair_wr_t1_i0   0 1 00001100 C0C0C0C0 12 0 00000000
pair_wr_t1_i1   1 1 00001104 C1C1C1C1 12 0 00000000
pair_rd_t1_i0   0 0 00001104 00000000 13 0 C1C1C1C1
pair_rd_t1_i1   1 0 00001100 00000000 13 0 C0C0C0C0
mix_wr_t1_i0    0 1 00001200 12001200 14 0 00000000
mix_err_i1      1 0 00003000 00000000 14 1 DEADBEEF
mix_rd_t1_i0    0 0 00001200 00000000 15 0 12001200
mix_rd_t0_i1    1 0 00000048 00000000 15 0 0000CC01
pair3_wr_t0_i0  0 1 00000040 AAAA0002 16 0 00000000
pair3_wr_t0_i1  1 1 00000080 DDDD0001 16 0 00000000
pair3_rd_t0_i0  0 0 00000080 00000000 17 0 DDDD0001
pair3_rd_t0_i1  1 0 00000040 00000000 17 0 AAAA0002

/* build.f */
source/xbar_pkg.sv
source/spill_reg.sv
source/addr_decoder.sv
source/initiator_demux.sv
source/target_mux.sv
source/lite_xbar.sv
verif/tb_lite_xbar.sv

/* Bender.yml */
package:
  name: lite_xbar

sources:
  # Package first, then leaf modules up to the top level
  - source/xbar_pkg.sv
  - source/spill_reg.sv
  - source/addr_decoder.sv
  - source/initiator_demux.sv
  - source/target_mux.sv
  - source/lite_xbar.sv

  - target: test
    files:
      - verif/tb_lite_xbar.sv
